// ==== logic/csr_pkg.sv ====
// CSR unit package: machine CSR types, addresses, write masks and trap codes
package csr_pkg;

  // Data and address words
  typedef logic [31:0] rdata_t;
  typedef logic [31:0] pc_t;

  // CSR operation, same encoding as funct3
  typedef enum logic [2:0] {
    CSR_NONE = 3'b000,
    CSR_RW   = 3'b001,
    CSR_RS   = 3'b010,
    CSR_RC   = 3'b011,
    CSR_RWI  = 3'b101,
    CSR_RSI  = 3'b110,
    CSR_RCI  = 3'b111
  } csr_op_e;

  typedef struct packed {
    csr_op_e     op;
    logic [11:0] addr;
  } s_csr_t;

  typedef struct packed {
    logic ext_irq;
    logic sw_irq;
    logic timer_irq;
  } s_irq_t;

  typedef struct packed {
    logic   active;
    pc_t    pc_addr;
    rdata_t mtval;
  } s_trap_info_t;

  // SYSTEM word seen as a CSR access
  typedef struct packed {
    logic [11:0] addr;
    logic [4:0]  uimm;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } s_csr_instr_t;

  // SYSTEM word seen as a privileged instruction
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } s_priv_instr_t;

  typedef union packed {
    s_csr_instr_t  csr_acc;
    s_priv_instr_t priv;
  } sys_instr_u;

  // Machine CSR addresses
  localparam logic [11:0] MSTATUS  = 12'h300;
  localparam logic [11:0] MISA     = 12'h301;
  localparam logic [11:0] MIE      = 12'h304;
  localparam logic [11:0] MTVEC    = 12'h305;
  localparam logic [11:0] MSCRATCH = 12'h340;
  localparam logic [11:0] MEPC     = 12'h341;
  localparam logic [11:0] MCAUSE   = 12'h342;
  localparam logic [11:0] MTVAL    = 12'h343;
  localparam logic [11:0] MIP      = 12'h344;
  localparam logic [11:0] CYCLE    = 12'hC00;
  localparam logic [11:0] CYCLEH   = 12'hC80;

  // Writable bits per register
  localparam rdata_t MSTATUS_WMASK = 32'h0000_0088;
  localparam rdata_t MIE_WMASK     = 32'h0000_0888;
  localparam rdata_t MTVEC_WMASK   = 32'hFFFF_FFFD;
  localparam rdata_t MEPC_WMASK    = 32'hFFFF_FFFC;
  localparam rdata_t MIP_WMASK     = 32'h0000_0008;

  // Bit positions in mstatus and mie/mip
  localparam int MST_MIE  = 3;
  localparam int MST_MPIE = 7;
  localparam int MIE_MSIP = 3;
  localparam int MIE_MTIP = 7;
  localparam int MIE_MEIP = 11;

  // mcause values
  localparam rdata_t MCAUSE_EXT_IRQ     = 32'h8000_000B;
  localparam rdata_t MCAUSE_SW_IRQ      = 32'h8000_0003;
  localparam rdata_t MCAUSE_TIMER_IRQ   = 32'h8000_0007;
  localparam rdata_t MCAUSE_FETCH_FAULT = 32'd0;
  localparam rdata_t MCAUSE_ILLEGAL     = 32'd2;
  localparam rdata_t MCAUSE_BREAKPOINT  = 32'd3;
  localparam rdata_t MCAUSE_ECALL       = 32'd11;

  // Offsets from mtvec base in vectored mode
  localparam rdata_t VEC_OFF_SW    = 32'h0C;
  localparam rdata_t VEC_OFF_TIMER = 32'h1C;
  localparam rdata_t VEC_OFF_EXT   = 32'h2C;

  localparam rdata_t MTVEC_RESET = 32'h0000_1000;
  // RV32I
  localparam rdata_t MISA_VALUE  = 32'h4000_0100;

  // SYSTEM opcode and privileged encodings
  localparam logic [6:0]  OPCODE_SYSTEM = 7'h73;
  localparam logic [2:0]  FUNCT3_PRIV   = 3'b000;
  localparam logic [2:0]  FUNCT3_RSVD   = 3'b100;
  localparam logic [11:0] F12_ECALL     = 12'h000;
  localparam logic [11:0] F12_EBREAK    = 12'h001;
  localparam logic [11:0] F12_MRET      = 12'h302;
  localparam logic [11:0] F12_WFI       = 12'h105;

endpackage

// ==== logic/sys_instr_decoder.sv ====
// SYSTEM instruction decoder: CSR access, ecall/ebreak/mret strobes and illegal trap
`timescale 1ns/100ps

module sys_instr_decoder (
  input  logic                  instr_valid_i,
  input  csr_pkg::sys_instr_u   instr_i,
  input  csr_pkg::pc_t          pc_i,
  output csr_pkg::s_csr_t       csr_o,
  output csr_pkg::rdata_t       imm_o,
  output logic                  ecall_o,
  output logic                  ebreak_o,
  output logic                  mret_o,
  output csr_pkg::s_trap_info_t dec_trap_o
);
  import csr_pkg::*;

  logic       is_system;
  logic [2:0] funct3;
  logic       illegal;

  // Only a valid SYSTEM word produces anything
  assign is_system = instr_valid_i && (instr_i.priv.opcode == OPCODE_SYSTEM);

  // funct3 sits at the same bits in both views
  assign funct3 = instr_i.priv.funct3;

  always_comb begin : decode
    csr_o    = '0;
    imm_o    = '0;
    ecall_o  = 1'b0;
    ebreak_o = 1'b0;
    mret_o   = 1'b0;
    illegal  = 1'b0;

    if (is_system) begin
      if (funct3 == FUNCT3_RSVD) begin
        // Reserved funct3 slot
        illegal = 1'b1;
      end else if (funct3 != FUNCT3_PRIV) begin
        // CSR view
        csr_o.op   = csr_op_e'(funct3);
        csr_o.addr = instr_i.csr_acc.addr;
        // Zero-extended uimm for the immediate forms
        imm_o      = {27'd0, instr_i.csr_acc.uimm};
      end else begin
        // Privileged view
        case (instr_i.priv.funct12)
          F12_ECALL: begin
            ecall_o = 1'b1;
          end
          F12_EBREAK: begin
            ebreak_o = 1'b1;
          end
          F12_MRET: begin
            mret_o = 1'b1;
          end
          F12_WFI: begin
            // No wait state, behaves as a nop
          end
          default: begin
            illegal = 1'b1;
          end
        endcase
      end
    end
  end

  // Illegal instruction trap info
  // mtval carries the raw word
  always_comb begin : trap_info
    dec_trap_o = '0;
    if (illegal) begin
      dec_trap_o.active  = 1'b1;
      dec_trap_o.pc_addr = pc_i;
      dec_trap_o.mtval   = instr_i;
    end
  end

endmodule

// ==== logic/irq_synchronizer.sv ====
// Interrupt synchronizer: two flops per line for external, software and timer IRQs
`timescale 1ns/100ps

module irq_synchronizer (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            irq_ext_i,
  input  logic            irq_sw_i,
  input  logic            irq_timer_i,
  output csr_pkg::s_irq_t irq_o
);
  import csr_pkg::*;

  s_irq_t irq_async;
  // First stage may go metastable
  s_irq_t meta_ff;
  s_irq_t sync_ff;

  assign irq_async.ext_irq   = irq_ext_i;
  assign irq_async.sw_irq    = irq_sw_i;
  assign irq_async.timer_irq = irq_timer_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_ff <= '0;
      sync_ff <= '0;
    end else begin
      meta_ff <= irq_async;
      sync_ff <= meta_ff;
    end
  end

  // Levels now safe in clk domain
  assign irq_o = sync_ff;

endmodule

// ==== logic/csr.sv ====
// Machine CSR file: read-modify-write, cycle counter, trap priority and trap target
`timescale 1ns/100ps

module csr (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  stall_i,
  input  csr_pkg::s_csr_t       csr_i,
  input  csr_pkg::rdata_t       rs1_data_i,
  input  csr_pkg::rdata_t       imm_i,
  input  csr_pkg::pc_t          pc_addr_i,
  input  csr_pkg::s_irq_t       irq_i,
  input  logic                  will_jump_i,
  input  csr_pkg::s_trap_info_t dec_trap_i,
  input  csr_pkg::s_trap_info_t fetch_trap_i,
  input  logic                  ecall_i,
  input  logic                  ebreak_i,
  input  logic                  mret_i,
  output csr_pkg::rdata_t       csr_rd_o,
  output csr_pkg::s_trap_info_t trap_o
);
  import csr_pkg::*;

  // Architectural registers
  rdata_t mstatus_ff, mstatus_next;
  rdata_t mie_ff, mie_next;
  rdata_t mtvec_ff, mtvec_next;
  rdata_t mscratch_ff, mscratch_next;
  rdata_t mepc_ff, mepc_next;
  rdata_t mcause_ff, mcause_next;
  rdata_t mtval_ff, mtval_next;
  rdata_t mip_ff, mip_next;
  logic [63:0] cycle_ff;

  // Registered trap/redirect
  s_trap_info_t trap_ff, trap_next;

  // Write path
  logic   wr_en;
  rdata_t wr_mask;
  rdata_t wr_val;

  // Trap selection
  logic   trap_take;
  logic   trap_mret;
  rdata_t vec_off;
  pc_t    mtvec_base;

  // New value before masking
  function automatic rdata_t csr_rmw(csr_op_e op, rdata_t old_val, rdata_t rs1, rdata_t imm);
    rdata_t res;
    case (op)
      CSR_RW:  res = rs1;
      CSR_RS:  res = old_val | rs1;
      CSR_RC:  res = old_val & ~rs1;
      CSR_RWI: res = imm;
      CSR_RSI: res = old_val | imm;
      CSR_RCI: res = old_val & ~imm;
      default: res = old_val;
    endcase
    return res;
  endfunction

  // Combinational read mux, also picks the write mask
  always_comb begin : csr_read
    csr_rd_o = '0;
    wr_mask  = '0;
    case (csr_i.addr)
      MSTATUS: begin
        csr_rd_o = mstatus_ff;
        wr_mask  = MSTATUS_WMASK;
      end
      MISA: begin
        csr_rd_o = MISA_VALUE;
      end
      MIE: begin
        csr_rd_o = mie_ff;
        wr_mask  = MIE_WMASK;
      end
      MTVEC: begin
        csr_rd_o = mtvec_ff;
        wr_mask  = MTVEC_WMASK;
      end
      MSCRATCH: begin
        csr_rd_o = mscratch_ff;
        wr_mask  = '1;
      end
      MEPC: begin
        csr_rd_o = mepc_ff;
        wr_mask  = MEPC_WMASK;
      end
      // Read-only to software
      MCAUSE: begin
        csr_rd_o = mcause_ff;
      end
      MTVAL: begin
        csr_rd_o = mtval_ff;
        wr_mask  = '1;
      end
      MIP: begin
        csr_rd_o = mip_ff;
        wr_mask  = MIP_WMASK;
      end
      CYCLE: begin
        csr_rd_o = cycle_ff[31:0];
      end
      CYCLEH: begin
        csr_rd_o = cycle_ff[63:32];
      end
      default: begin
        // Unimplemented, reads zero
        csr_rd_o = '0;
      end
    endcase
  end

  // Stall drops the write only, read still goes out
  assign wr_en  = (csr_i.op != CSR_NONE) && !stall_i;
  assign wr_val = csr_rmw(csr_i.op, csr_rd_o, rs1_data_i, imm_i) & wr_mask;

  assign mtvec_base = {mtvec_ff[31:2], 2'b00};

  always_comb begin : csr_next
    mstatus_next  = mstatus_ff;
    mie_next      = mie_ff;
    mtvec_next    = mtvec_ff;
    mscratch_next = mscratch_ff;
    mepc_next     = mepc_ff;
    mcause_next   = mcause_ff;
    mtval_next    = mtval_ff;
    mip_next      = mip_ff;

    // Software writes first, traps override below
    if (wr_en) begin
      case (csr_i.addr)
        MSTATUS:  mstatus_next  = wr_val;
        MIE:      mie_next      = wr_val;
        MTVEC:    mtvec_next    = wr_val;
        MSCRATCH: mscratch_next = wr_val;
        MEPC:     mepc_next     = wr_val;
        MTVAL:    mtval_next    = wr_val;
        MIP:      mip_next      = wr_val;
        default: begin
          // Read-only or unimplemented, write dropped
        end
      endcase
    end

    trap_take = 1'b0;
    trap_mret = 1'b0;
    vec_off   = '0;

    // Priority: irqs, decode trap, fetch fault, ecall, ebreak, mret
    if (mstatus_ff[MST_MIE] && irq_i.ext_irq && mie_ff[MIE_MEIP]) begin
      mip_next[MIE_MEIP] = 1'b1;
      mepc_next          = pc_addr_i;
      mcause_next        = MCAUSE_EXT_IRQ;
      vec_off            = VEC_OFF_EXT;
      trap_take          = 1'b1;
    end else if (mstatus_ff[MST_MIE] && irq_i.sw_irq && mie_ff[MIE_MSIP]) begin
      mip_next[MIE_MSIP] = 1'b1;
      mepc_next          = pc_addr_i;
      mcause_next        = MCAUSE_SW_IRQ;
      vec_off            = VEC_OFF_SW;
      trap_take          = 1'b1;
    end else if (mstatus_ff[MST_MIE] && irq_i.timer_irq && mie_ff[MIE_MTIP]) begin
      mip_next[MIE_MTIP] = 1'b1;
      mepc_next          = pc_addr_i;
      mcause_next        = MCAUSE_TIMER_IRQ;
      vec_off            = VEC_OFF_TIMER;
      trap_take          = 1'b1;
    end else if (dec_trap_i.active && !will_jump_i) begin
      // Shadow of a taken branch, not executed
      mepc_next   = dec_trap_i.pc_addr;
      mcause_next = MCAUSE_ILLEGAL;
      mtval_next  = dec_trap_i.mtval;
      trap_take   = 1'b1;
    end else if (fetch_trap_i.active) begin
      mepc_next   = fetch_trap_i.pc_addr;
      mcause_next = MCAUSE_FETCH_FAULT;
      mtval_next  = fetch_trap_i.mtval;
      trap_take   = 1'b1;
    end else if (ecall_i) begin
      mepc_next   = pc_addr_i;
      mcause_next = MCAUSE_ECALL;
      mtval_next  = '0;
      trap_take   = 1'b1;
    end else if (ebreak_i) begin
      mepc_next   = pc_addr_i;
      mcause_next = MCAUSE_BREAKPOINT;
      mtval_next  = '0;
      trap_take   = 1'b1;
    end else if (mret_i) begin
      // Return redirect uses the trap path
      trap_take = 1'b1;
      trap_mret = 1'b1;
    end

    trap_next = '0;
    if (trap_take) begin
      trap_next.active = 1'b1;
      if (trap_mret) begin
        // Back to mepc, pop interrupt enable
        trap_next.pc_addr      = mepc_ff;
        mstatus_next[MST_MIE]  = mstatus_ff[MST_MPIE];
        mstatus_next[MST_MPIE] = 1'b1;
      end else begin
        // Vector offset only nonzero for irqs
        trap_next.pc_addr      = mtvec_ff[0] ? mtvec_base + vec_off : mtvec_base;
        trap_next.mtval        = mtval_next;
        // Push interrupt enable
        mstatus_next[MST_MPIE] = mstatus_ff[MST_MIE];
        mstatus_next[MST_MIE]  = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_ff  <= '0;
      mie_ff      <= '0;
      mtvec_ff    <= MTVEC_RESET;
      mscratch_ff <= '0;
      mepc_ff     <= '0;
      mcause_ff   <= '0;
      mtval_ff    <= '0;
      mip_ff      <= '0;
      cycle_ff    <= '0;
      trap_ff     <= '0;
    end else begin
      mstatus_ff  <= mstatus_next;
      mie_ff      <= mie_next;
      mtvec_ff    <= mtvec_next;
      mscratch_ff <= mscratch_next;
      mepc_ff     <= mepc_next;
      mcause_ff   <= mcause_next;
      mtval_ff    <= mtval_next;
      mip_ff      <= mip_next;
      // Free running
      cycle_ff    <= cycle_ff + 64'd1;
      trap_ff     <= trap_next;
    end
  end

  assign trap_o = trap_ff;

endmodule

// ==== logic/csr_unit_top.sv ====
// CSR unit top: SYSTEM decoder, IRQ synchronizer and machine CSR file
`timescale 1ns/100ps

module csr_unit_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  csr_pkg::sys_instr_u   instr_i,
  input  csr_pkg::pc_t          pc_i,
  input  csr_pkg::rdata_t       rs1_data_i,
  input  logic                  jump_i,
  input  logic                  stall_i,
  input  csr_pkg::s_trap_info_t fetch_trap_i,
  input  logic                  irq_ext_i,
  input  logic                  irq_sw_i,
  input  logic                  irq_timer_i,
  output csr_pkg::rdata_t       csr_rd_o,
  output csr_pkg::s_trap_info_t trap_o
);
  import csr_pkg::*;

  // Decoder to CSR file
  s_csr_t       csr_op;
  rdata_t       csr_imm;
  logic         ecall;
  logic         ebreak;
  logic         mret;
  s_trap_info_t dec_trap;

  // Synchronized irq levels
  s_irq_t       irq_sync;

  sys_instr_decoder u_decoder (
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .csr_o         (csr_op),
    .imm_o         (csr_imm),
    .ecall_o       (ecall),
    .ebreak_o      (ebreak),
    .mret_o        (mret),
    .dec_trap_o    (dec_trap)
  );

  irq_synchronizer u_irq_sync (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .irq_ext_i   (irq_ext_i),
    .irq_sw_i    (irq_sw_i),
    .irq_timer_i (irq_timer_i),
    .irq_o       (irq_sync)
  );

  csr u_csr (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .csr_i        (csr_op),
    .rs1_data_i   (rs1_data_i),
    .imm_i        (csr_imm),
    .pc_addr_i    (pc_i),
    .irq_i        (irq_sync),
    .will_jump_i  (jump_i),
    .dec_trap_i   (dec_trap),
    .fetch_trap_i (fetch_trap_i),
    .ecall_i      (ecall),
    .ebreak_i     (ebreak),
    .mret_i       (mret),
    .csr_rd_o     (csr_rd_o),
    .trap_o       (trap_o)
  );

endmodule

// ==== verification/csr_unit_assertions.sv ====
// CSR file trap assertions: redirect pulse width, mcause updates and MIE push
`timescale 1ns/100ps

module csr_unit_assertions (
  input logic                  clk,
  input logic                  rst_n_i,
  input csr_pkg::rdata_t       mstatus_ff,
  input csr_pkg::rdata_t       mie_ff,
  input csr_pkg::rdata_t       mcause_ff,
  input csr_pkg::s_irq_t       irq_i,
  input csr_pkg::s_trap_info_t dec_trap_i,
  input logic                  will_jump_i,
  input csr_pkg::s_trap_info_t fetch_trap_i,
  input logic                  ecall_i,
  input logic                  ebreak_i,
  input csr_pkg::s_trap_info_t trap_o
);
  import csr_pkg::*;

  logic irq_pending;
  logic exc_pending;

  // Enabled interrupt with MIE set
  assign irq_pending = mstatus_ff[MST_MIE] &&
                       ((irq_i.ext_irq && mie_ff[MIE_MEIP]) ||
                        (irq_i.sw_irq && mie_ff[MIE_MSIP]) ||
                        (irq_i.timer_irq && mie_ff[MIE_MTIP]));

  // Any exception source, all outrank mret
  assign exc_pending = (dec_trap_i.active && !will_jump_i) || fetch_trap_i.active ||
                       ecall_i || ebreak_i;

  // Redirect is a single-cycle pulse
  a_trap_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    trap_o.active |=> !trap_o.active)
    else $error("trap_o.active stayed high for two cycles");

  // mcause moves only together with a redirect
  a_mcause_on_trap: assert property (@(posedge clk) disable iff (!rst_n_i)
    (mcause_ff != $past(mcause_ff)) |-> trap_o.active)
    else $error("mcause changed without a trap");

  // Trap entry masks interrupts
  a_mie_cleared: assert property (@(posedge clk) disable iff (!rst_n_i)
    (irq_pending || exc_pending) |=> !mstatus_ff[MST_MIE])
    else $error("mstatus.MIE still set after trap entry");

endmodule

bind csr csr_unit_assertions u_csr_assertions (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .mstatus_ff   (mstatus_ff),
  .mie_ff       (mie_ff),
  .mcause_ff    (mcause_ff),
  .irq_i        (irq_i),
  .dec_trap_i   (dec_trap_i),
  .will_jump_i  (will_jump_i),
  .fetch_trap_i (fetch_trap_i),
  .ecall_i      (ecall_i),
  .ebreak_i     (ebreak_i),
  .trap_o       (trap_o)
);

// ==== verification/csr_unit_tb.sv ====
// CSR unit testbench: directed CSR, counter, exception, interrupt and mret tests
`timescale 1ns/100ps

module csr_unit_tb;
  import csr_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int SEED       = 32'h098b5305;
  // Rough cycle cost per test, plus slack
  localparam int RESET_LEN  = 20;
  localparam int OPS_LEN    = 200;
  localparam int CYCLE_LEN  = 50;
  localparam int EXC_LEN    = 120;
  localparam int IRQ_LEN    = 60;
  localparam int MRET_LEN   = 20;
  localparam int MARGIN_LEN = 1500;
  localparam int WATCHDOG_CYCLES = RESET_LEN + OPS_LEN + CYCLE_LEN + EXC_LEN + IRQ_LEN
                                   + MRET_LEN + MARGIN_LEN;

  logic         clk;
  logic         rst_n;
  logic         instr_valid;
  sys_instr_u   instr;
  pc_t          pc;
  rdata_t       rs1_data;
  logic         jump;
  logic         stall;
  s_trap_info_t fetch_trap;
  logic         irq_ext;
  logic         irq_sw;
  logic         irq_timer;
  rdata_t       csr_rd;
  s_trap_info_t trap;

  // Bookkeeping
  string cur_test;
  int    err_count;
  int    test_errs_start;
  int    test_count;
  int    failed_count;
  int    seed_dummy;

  csr_unit_top u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .rs1_data_i    (rs1_data),
    .jump_i        (jump),
    .stall_i       (stall),
    .fetch_trap_i  (fetch_trap),
    .irq_ext_i     (irq_ext),
    .irq_sw_i      (irq_sw),
    .irq_timer_i   (irq_timer),
    .csr_rd_o      (csr_rd),
    .trap_o        (trap)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // CSR access word, src lands in rs1/uimm
  function automatic sys_instr_u csr_word(csr_op_e op, logic [11:0] addr, logic [4:0] src);
    sys_instr_u w;
    w = '0;
    w.csr_acc.addr   = addr;
    w.csr_acc.uimm   = src;
    w.csr_acc.funct3 = op;
    w.csr_acc.rd     = 5'd1;
    w.csr_acc.opcode = OPCODE_SYSTEM;
    return w;
  endfunction

  function automatic sys_instr_u priv_word(logic [11:0] funct12);
    sys_instr_u w;
    w = '0;
    w.priv.funct12 = funct12;
    w.priv.opcode  = OPCODE_SYSTEM;
    return w;
  endfunction

  // Drive point: 1 ns past the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // pc and irq lines are left as they are
  task automatic drive_idle();
    instr_valid = 1'b0;
    instr       = '0;
    rs1_data    = '0;
    jump        = 1'b0;
    stall       = 1'b0;
    fetch_trap  = '0;
  endtask

  task automatic check_value(input string what, input rdata_t exp, input rdata_t act);
    if (act !== exp) begin
      $display("Error: %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    test_errs_start = err_count;
  endtask

  task automatic finish_test();
    test_count++;
    if (err_count == test_errs_start) begin
      $display("Test %s: ok", cur_test);
    end else begin
      failed_count++;
      $display("Test %s: %0d errors", cur_test, err_count - test_errs_start);
    end
  endtask

  // One instruction cycle; read sampled mid-cycle
  task automatic run_csr_instr(input sys_instr_u w, input rdata_t rs1, input logic hold,
                               output rdata_t rd);
    instr_valid = 1'b1;
    instr       = w;
    rs1_data    = rs1;
    stall       = hold;
    #3;
    rd = csr_rd;
    next_cycle();
    drive_idle();
  endtask

  // Stall keeps the read free of side effects
  task automatic read_csr(input logic [11:0] addr, output rdata_t rd);
    run_csr_instr(csr_word(CSR_RS, addr, 5'd0), '0, 1'b1, rd);
  endtask

  task automatic write_csr(input logic [11:0] addr, input rdata_t val);
    rdata_t rd;
    run_csr_instr(csr_word(CSR_RW, addr, 5'd0), val, 1'b0, rd);
  endtask

  task automatic check_csr(input string what, input logic [11:0] addr, input rdata_t exp);
    rdata_t rd;
    read_csr(addr, rd);
    check_value(what, exp, rd);
  endtask

  // Privileged word for one cycle, trap_o is visible on return
  task automatic run_priv_instr(input sys_instr_u w, input pc_t at_pc);
    instr_valid = 1'b1;
    instr       = w;
    pc          = at_pc;
    next_cycle();
    drive_idle();
  endtask

  task automatic check_trap_taken(input string what, input pc_t target, input pc_t epc,
                                  input rdata_t cause, input rdata_t tval);
    check_value({what, " active"}, 32'd1, 32'(trap.active));
    check_value({what, " target"}, target, trap.pc_addr);
    check_value({what, " trap mtval"}, tval, trap.mtval);
    next_cycle();
    check_value({what, " pulse end"}, 32'd0, 32'(trap.active));
    check_csr({what, " mepc"}, MEPC, epc);
    check_csr({what, " mcause"}, MCAUSE, cause);
    check_csr({what, " mtval"}, MTVAL, tval);
  endtask

  task automatic check_reset_values();
    start_test("reset_values");
    check_value("trap active", 32'd0, 32'(trap.active));
    check_csr("mstatus", MSTATUS, 32'd0);
    check_csr("misa", MISA, MISA_VALUE);
    check_csr("mie", MIE, 32'd0);
    check_csr("mtvec", MTVEC, MTVEC_RESET);
    check_csr("mscratch", MSCRATCH, 32'd0);
    check_csr("mepc", MEPC, 32'd0);
    check_csr("mcause", MCAUSE, 32'd0);
    check_csr("mtval", MTVAL, 32'd0);
    check_csr("mip", MIP, 32'd0);
    check_csr("unimplemented", 12'h7C0, 32'd0);
    finish_test();
  endtask

  task automatic exercise_csr_ops();
    logic [11:0] regs [4];
    rdata_t      masks [4];
    rdata_t      resets [4];
    csr_op_e     ops [6];
    rdata_t      model;
    rdata_t      operand;
    rdata_t      src;
    rdata_t      exp;
    rdata_t      rd;
    int          r;
    int          k;
    start_test("csr_ops");
    regs   = '{MSCRATCH, MIE, MTVEC, MEPC};
    masks  = '{32'hFFFF_FFFF, MIE_WMASK, MTVEC_WMASK, MEPC_WMASK};
    resets = '{32'd0, 32'd0, MTVEC_RESET, 32'd0};
    ops    = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
    for (r = 0; r < 4; r++) begin
      // Untouched since reset
      model = resets[r];
      for (k = 0; k < 6; k++) begin
        operand = $urandom;
        // Immediate forms take the zero-extended 5-bit field
        src = (k >= 3) ? {27'd0, operand[4:0]} : operand;
        case (k % 3)
          0:       exp = src;
          1:       exp = model | src;
          default: exp = model & ~src;
        endcase
        exp = exp & masks[r];
        run_csr_instr(csr_word(ops[k], regs[r], operand[4:0]), operand, 1'b0, rd);
        check_value($sformatf("old value %h op %0d", regs[r], k), model, rd);
        check_csr($sformatf("new value %h op %0d", regs[r], k), regs[r], exp);
        model = exp;
      end
      // Stall cancels the write
      run_csr_instr(csr_word(CSR_RW, regs[r], 5'd0), ~model, 1'b1, rd);
      check_value($sformatf("stalled read %h", regs[r]), model, rd);
      check_csr($sformatf("stalled write %h", regs[r]), regs[r], model);
    end
    // No trap yet, mcause still at reset
    write_csr(MCAUSE, $urandom);
    check_csr("mcause write", MCAUSE, 32'd0);
    finish_test();
  endtask

  task automatic measure_cycle_counter();
    rdata_t c0;
    rdata_t c1;
    int     k;
    start_test("cycle_counter");
    k = 5 + ($urandom % 32);
    read_csr(CYCLE, c0);
    repeat (k - 1) next_cycle();
    read_csr(CYCLE, c1);
    check_value("cycle delta", rdata_t'(k), c1 - c0);
    finish_test();
  endtask

  task automatic raise_exceptions();
    pc_t    at_pc;
    pc_t    fpc;
    rdata_t fval;
    start_test("exceptions");
    // Vectored bit set, exceptions still go to the base
    write_csr(MTVEC, 32'h0000_2001);
    at_pc = $urandom & 32'hFFFF_FFFC;
    run_priv_instr(priv_word(F12_ECALL), at_pc);
    check_trap_taken("ecall", 32'h2000, at_pc, MCAUSE_ECALL, 32'd0);
    at_pc = $urandom & 32'hFFFF_FFFC;
    run_priv_instr(priv_word(F12_EBREAK), at_pc);
    check_trap_taken("ebreak", 32'h2000, at_pc, MCAUSE_BREAKPOINT, 32'd0);
    at_pc = $urandom & 32'hFFFF_FFFC;
    run_priv_instr(priv_word(12'h7FF), at_pc);
    check_trap_taken("illegal", 32'h2000, at_pc, MCAUSE_ILLEGAL, priv_word(12'h7FF));
    // Fetch fault outranks ecall
    fpc  = $urandom & 32'hFFFF_FFFC;
    fval = $urandom;
    fetch_trap.active  = 1'b1;
    fetch_trap.pc_addr = fpc;
    fetch_trap.mtval   = fval;
    run_priv_instr(priv_word(F12_ECALL), $urandom & 32'hFFFF_FFFC);
    check_trap_taken("fetch fault", 32'h2000, fpc, MCAUSE_FETCH_FAULT, fval);
    // Illegal word in a branch shadow
    jump = 1'b1;
    run_priv_instr(priv_word(12'h7FF), $urandom & 32'hFFFF_FFFC);
    check_value("jump shadow active", 32'd0, 32'(trap.active));
    check_csr("jump shadow mcause", MCAUSE, MCAUSE_FETCH_FAULT);
    finish_test();
  endtask

  task automatic take_interrupts();
    pc_t irq_pc;
    int  i;
    start_test("interrupts");
    write_csr(MTVEC, 32'h0000_3001);
    write_csr(MIE, MIE_WMASK);
    write_csr(MSTATUS, 32'h0000_0008);
    irq_pc    = $urandom & 32'hFFFF_FFFC;
    pc        = irq_pc;
    irq_ext   = 1'b1;
    irq_sw    = 1'b1;
    irq_timer = 1'b1;
    // Two synchronizer edges, then the trap edge
    for (i = 1; i <= 2; i++) begin
      next_cycle();
      check_value($sformatf("early trap edge %0d", i), 32'd0, 32'(trap.active));
    end
    next_cycle();
    check_value("ext active", 32'd1, 32'(trap.active));
    check_value("ext target", 32'h3000 + VEC_OFF_EXT, trap.pc_addr);
    next_cycle();
    check_value("ext pulse end", 32'd0, 32'(trap.active));
    check_csr("ext mcause", MCAUSE, MCAUSE_EXT_IRQ);
    check_csr("ext mepc", MEPC, irq_pc);
    check_csr("ext mstatus", MSTATUS, 32'h0000_0080);
    check_csr("ext mip", MIP, 32'h0000_0800);
    irq_ext = 1'b0;
    repeat (3) next_cycle();
    // Set MIE, keep MPIE
    write_csr(MSTATUS, 32'h0000_0088);
    // Software line still high, taken at the next edge
    next_cycle();
    check_value("sw active", 32'd1, 32'(trap.active));
    check_value("sw target", 32'h3000 + VEC_OFF_SW, trap.pc_addr);
    next_cycle();
    check_csr("sw mcause", MCAUSE, MCAUSE_SW_IRQ);
    check_csr("sw mepc", MEPC, irq_pc);
    irq_sw    = 1'b0;
    irq_timer = 1'b0;
    repeat (3) next_cycle();
    finish_test();
  endtask

  task automatic return_with_mret();
    rdata_t epc;
    start_test("mret");
    // MIE clear and MPIE set from the last trap
    check_csr("mstatus before", MSTATUS, 32'h0000_0080);
    epc = $urandom & 32'hFFFF_FFFC;
    write_csr(MEPC, epc);
    run_priv_instr(priv_word(F12_MRET), $urandom & 32'hFFFF_FFFC);
    check_value("mret active", 32'd1, 32'(trap.active));
    check_value("mret target", epc, trap.pc_addr);
    next_cycle();
    check_value("mret pulse end", 32'd0, 32'(trap.active));
    check_csr("mstatus after", MSTATUS, 32'h0000_0088);
    finish_test();
  endtask

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    seed_dummy   = $urandom(SEED);
    err_count    = 0;
    test_count   = 0;
    failed_count = 0;
    rst_n        = 1'b0;
    pc           = '0;
    irq_ext      = 1'b0;
    irq_sw       = 1'b0;
    irq_timer    = 1'b0;
    drive_idle();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_values();
    exercise_csr_ops();
    measure_cycle_counter();
    raise_exceptions();
    take_interrupts();
    return_with_mret();
    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== csr_unit.f ====
logic/csr_pkg.sv
logic/sys_instr_decoder.sv
logic/irq_synchronizer.sv
logic/csr.sv
logic/csr_unit_top.sv
verification/csr_unit_assertions.sv
verification/csr_unit_tb.sv
